// File: Makefile
# Verilator build and run for the slm bridge testbench

all: build run

build:
	verilator --binary --timing --assert -f src.f --top-module tb_top -o Vtb_top

run:
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only --timing -f src.f --top-module tb_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: bench/bridge_props.sv
// protocol assertions for the slm bridge
// readback fifo flags and spi clock idle level
`timescale 1ns/1ps

module bridge_props (
  input logic fpga_clk,
  input logic reset_all_cmd_w,
  input logic rb_full_i,
  input logic rb_empty_i,
  input logic rb_wr_en_i,
  input logic rb_rd_en_i,
  input logic spi_cs_n_i,
  input logic spi_sck_i
);

  // fifo can never be both
  full_empty_excl: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    !(rb_full_i && rb_empty_i))
    else $error("fifo full and empty together");

  // write into a full fifo without a read leaves it full
  no_write_when_full: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    (rb_full_i && rb_wr_en_i && !rb_rd_en_i) |=> rb_full_i)
    else $error("fifo accepted a write while full");

  // sck idles low outside a frame
  sck_low_when_idle: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_cs_n_i |-> !spi_sck_i)
    else $error("sck high while chip select deasserted");

endmodule

// fifo and spi master meet in the top
bind slm_bridge_top bridge_props i_props (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .rb_full_i       (rb_full),
  .rb_empty_i      (rb_empty),
  .rb_wr_en_i      (rb_wr_en),
  .rb_rd_en_i      (rb_rd_en),
  .spi_cs_n_i      (spi_cs_n_o),
  .spi_sck_i       (spi_sck_o)
);

// File: bench/tb_checker.sv
// scoreboard for the slm bridge
// builds expected spi frames and readback bytes from the sent bytes,
// watches spi and uart pins and counts mismatches
`timescale 1ns/1ps

module tb_checker import link_pkg::*, slm_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  logic  uart_tx_i,
  input  logic  spi_cs_n_i,
  input  logic  spi_sck_i,
  input  logic  spi_mosi_i,
  input  logic  slm_reset_n_i,
  input  logic  sent_stb_i,
  input  byte_t sent_byte_i,
  input  logic  stim_done_i,
  output logic  done_o,
  output int    spi_err_o,
  output int    uart_err_o,
  output int    misc_err_o
);

  byte_t       exp_addr_q[$];
  byte_t       exp_data_q[$];
  byte_t       exp_rb_q[$];
  byte_t       pend_addr;
  byte_t       exp_a;
  byte_t       exp_d;
  byte_t       u_byte;
  logic        have_addr = 1'b0;
  logic        prev_burst = 1'b0;
  logic        rst_d = 1'b1;
  logic        sck_d = 1'b0;
  logic        cs_d = 1'b1;
  logic        u_busy = 1'b0;
  logic [15:0] frame_sh;
  int          pairs = 0;
  int          burst_follow = 0;
  int          cs_windows = 0;
  int          frames_seen = 0;
  int          rb_seen = 0;
  int          reset_low = 0;
  int          bit_cnt = 0;
  int          u_cnt = 0;
  int          u_n;
  int          exp_windows;
  int          spi_err = 0;
  int          uart_err = 0;
  int          misc_err = 0;
  logic        done_q = 1'b0;

  always @(posedge fpga_clk) begin
    ////////////////////////////////////////////////////////////
    // reset release and idle levels
    ////////////////////////////////////////////////////////////
    if (!reset_all_cmd_w && !slm_reset_n_i) begin
      reset_low++;
    end
    if (!reset_all_cmd_w && rst_d) begin
      if (spi_cs_n_i !== 1'b1 || spi_sck_i !== 1'b0 || spi_mosi_i !== 1'b0 ||
          uart_tx_i !== 1'b1) begin
        $display("FAILED @%0t: idle levels cs_n=%b sck=%b mosi=%b tx=%b", $time,
                 spi_cs_n_i, spi_sck_i, spi_mosi_i, uart_tx_i);
        misc_err++;
      end
    end

    // expected traffic from the host bytes
    if (sent_stb_i) begin
      if (!have_addr) begin
        pend_addr = sent_byte_i;
        have_addr = 1'b1;
      end else begin
        exp_addr_q.push_back(pend_addr);
        exp_data_q.push_back(sent_byte_i);
        exp_rb_q.push_back(pend_addr ^ 8'h5A);
        // burst followed by another frame merges two windows
        if (pairs > 0 && prev_burst) begin
          burst_follow++;
        end
        prev_burst = (pend_addr == byte_t'(OP_LINE_BURST));
        pairs++;
        have_addr = 1'b0;
      end
    end

    ////////////////////////////////////////////////////////////
    // spi monitor
    ////////////////////////////////////////////////////////////
    if (!reset_all_cmd_w) begin
      if (!spi_cs_n_i && cs_d) begin
        cs_windows++;
      end
      if (spi_cs_n_i && !cs_d && bit_cnt != 0) begin
        $display("error: chip select released after %0d rising sck edges", bit_cnt);
        spi_err++;
      end
      if (spi_sck_i && !sck_d) begin
        if (spi_cs_n_i) begin
          $display("error: rising sck while chip select is high");
          spi_err++;
        end
        frame_sh = {frame_sh[14:0], spi_mosi_i};
        bit_cnt++;
        if (bit_cnt == SPI_FRAME_BITS) begin
          bit_cnt = 0;
          frames_seen++;
          if (exp_addr_q.size() == 0) begin
            $display("error: spi frame %h with no command sent", frame_sh);
            spi_err++;
          end else begin
            exp_a = exp_addr_q.pop_front();
            exp_d = exp_data_q.pop_front();
            if (frame_sh != {exp_a, exp_d}) begin
              $display("FAILED @%0t: spi frame %h, expected %h%h", $time,
                       frame_sh, exp_a, exp_d);
              spi_err++;
            end
          end
        end
      end
    end
    sck_d = spi_sck_i;
    cs_d  = spi_cs_n_i;
    rst_d = reset_all_cmd_w;

    ////////////////////////////////////////////////////////////
    // uart monitor, samples at bit centres
    ////////////////////////////////////////////////////////////
    if (!u_busy) begin
      if (!reset_all_cmd_w && uart_tx_i === 1'b0) begin
        u_busy = 1'b1;
        u_cnt  = 0;
      end
    end else begin
      u_cnt++;
      if (u_cnt >= CLKS_PER_BIT / 2 && (u_cnt - CLKS_PER_BIT / 2) % CLKS_PER_BIT == 0) begin
        u_n = (u_cnt - CLKS_PER_BIT / 2) / CLKS_PER_BIT;
        if (u_n >= 1 && u_n <= 8) begin
          u_byte[u_n-1] = uart_tx_i;
        end else if (u_n == 9) begin
          u_busy = 1'b0;
          rb_seen++;
          if (uart_tx_i !== 1'b1) begin
            $display("error: uart byte %h has a low stop bit", u_byte);
            uart_err++;
          end
          if (exp_rb_q.size() == 0) begin
            $display("error: uart byte %h arrived with no frame pending", u_byte);
            uart_err++;
          end else begin
            exp_a = exp_rb_q.pop_front();
            if (u_byte != exp_a) begin
              $display("FAILED @%0t: readback %h, expected %h", $time, u_byte, exp_a);
              uart_err++;
            end
          end
        end
      end
    end

    // end of run checks, once everything came back
    if (stim_done_i && !have_addr && !done_q && !u_busy &&
        frames_seen == pairs && rb_seen == pairs) begin
      exp_windows = pairs - burst_follow;
      if (cs_windows != exp_windows) begin
        $display("FAILED @%0t: %0d chip select windows, expected %0d", $time,
                 cs_windows, exp_windows);
        spi_err++;
      end
      if (reset_low != RESET_HOLD_CYCLES) begin
        $display("FAILED @%0t: display reset low %0d cycles, expected %0d", $time,
                 reset_low, RESET_HOLD_CYCLES);
        misc_err++;
      end
      done_q = 1'b1;
    end
  end

  assign done_o     = done_q;
  assign spi_err_o  = spi_err;
  assign uart_err_o = uart_err;
  assign misc_err_o = misc_err;

endmodule

// File: bench/tb_clk_gen.sv
// testbench clock source
// free running fpga_clk, 20 ns period
`timescale 1ns/1ps

module tb_clk_gen (
  output logic fpga_clk_o
);

  initial begin
    fpga_clk_o = 1'b0;
  end

  // half period 10 ns
  always #10 fpga_clk_o = !fpga_clk_o;

endmodule

// File: bench/tb_top.sv
// testbench top for the slm bridge
// resets the DUT, sends random command bytes over uart,
// models the display driver as an spi slave
`timescale 1ns/1ps

module tb_top import link_pkg::*; ();

  localparam int NUM_BYTES = 40;
  localparam int TIMEOUT_CYCLES = NUM_BYTES * 10 * CLKS_PER_BIT * 2 + 2000;

  logic       fpga_clk;
  logic       reset_all_cmd_w;
  logic       uart_rx;
  logic       uart_tx;
  logic       spi_cs_n;
  logic       spi_sck;
  logic       spi_mosi;
  logic       spi_miso;
  logic       slm_reset_n;
  logic       sent_stb;
  byte_t      sent_byte;
  logic       stim_done;
  logic       chk_done;
  int         spi_err;
  int         uart_err;
  int         misc_err;
  int         cycle_cnt = 0;
  logic [3:0] rise_cnt = 4'd0;
  byte_t      addr_sh = '0;
  byte_t      reply;

  tb_clk_gen i_clk (.fpga_clk_o(fpga_clk));

  slm_bridge_top i_dut (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx),
    .uart_tx_o       (uart_tx),
    .spi_cs_n_o      (spi_cs_n),
    .spi_sck_o       (spi_sck),
    .spi_mosi_o      (spi_mosi),
    .spi_miso_i      (spi_miso),
    .slm_reset_n_o   (slm_reset_n)
  );

  tb_checker i_chk (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_tx_i       (uart_tx),
    .spi_cs_n_i      (spi_cs_n),
    .spi_sck_i       (spi_sck),
    .spi_mosi_i      (spi_mosi),
    .slm_reset_n_i   (slm_reset_n),
    .sent_stb_i      (sent_stb),
    .sent_byte_i     (sent_byte),
    .stim_done_i     (stim_done),
    .done_o          (chk_done),
    .spi_err_o       (spi_err),
    .uart_err_o      (uart_err),
    .misc_err_o      (misc_err)
  );

  ////////////////////////////////////////////////////////////
  // spi slave model
  ////////////////////////////////////////////////////////////
  // address in on the first 8 rises, reply out during the data half
  always @(posedge spi_sck) begin
    if (rise_cnt < 4'd8) begin
      addr_sh <= {addr_sh[6:0], spi_mosi};
    end
    rise_cnt <= rise_cnt + 4'd1;
  end

  assign reply = addr_sh ^ 8'h5A;

  // miso changes on falling sck, MSB first
  always @(negedge spi_sck) begin
    if (rise_cnt >= 4'd8) begin
      spi_miso <= #1 reply[3'(4'd15 - rise_cnt)];
    end
  end

  // one uart bit, driven just after the edge
  task automatic hold_bit();
    repeat (CLKS_PER_BIT) @(posedge fpga_clk);
    #1;
  endtask

  task automatic send_uart_byte(input byte_t b);
    sent_byte = b;
    sent_stb  = 1'b1;
    uart_rx   = 1'b0;
    @(posedge fpga_clk);
    #1;
    sent_stb = 1'b0;
    repeat (CLKS_PER_BIT - 1) @(posedge fpga_clk);
    #1;
    for (int i = 0; i < BYTE_W; i++) begin
      uart_rx = b[i];
      hold_bit();
    end
    uart_rx = 1'b1;
    hold_bit();
  endtask

  // run limit
  always @(posedge fpga_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    byte_t b;
    int    gap;
    void'($urandom(97026));
    reset_all_cmd_w = 1'b1;
    uart_rx         = 1'b1;
    spi_miso        = 1'b0;
    sent_stb        = 1'b0;
    sent_byte       = '0;
    stim_done       = 1'b0;
    repeat (10) @(posedge fpga_clk);
    #1;
    reset_all_cmd_w = 1'b0;
    repeat (20) @(posedge fpga_clk);
    #1;
    for (int i = 0; i < NUM_BYTES; i++) begin
      b = byte_t'($urandom);
      // roughly one address in four is a line burst
      if (i % 2 == 0 && $urandom_range(3) == 0) begin
        b = 8'hBC;
      end
      send_uart_byte(b);
      gap = $urandom_range(100);
      repeat (gap) @(posedge fpga_clk);
      #1;
    end
    stim_done = 1'b1;
    wait (chk_done);
    @(posedge fpga_clk);
    $display("errors: spi %0d, uart %0d, other %0d", spi_err, uart_err, misc_err);
    if (spi_err + uart_err + misc_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
src/link_pkg.sv
src/slm_pkg.sv
src/uart_rx.sv
src/spi_cmd_master.sv
src/readback_fifo.sv
src/uart_readback_tx.sv
src/slm_bridge_top.sv
bench/tb_clk_gen.sv
bench/bridge_props.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: src/link_pkg.sv
// serial side definitions
// uart bit timing, readback buffer sizing and the byte type
// shared by the receiver, the transmitter, the fifo and the top

package link_pkg;

  // uart timing, fpga_clk cycles per bit
  localparam int CLKS_PER_BIT = 20;

  // one serial byte
  localparam int BYTE_W = 8;
  typedef logic [BYTE_W-1:0] byte_t;

  // readback buffer between spi and uart tx
  localparam int RB_DEPTH = 4;
  localparam int RB_PTR_W = 2;

  // display reset stretch after the reset command
  localparam int RESET_HOLD_CYCLES = 10;

endpackage

// File: src/readback_fifo.sv
// readback buffer between the spi master and the uart tx
// small register fifo, head entry visible combinationally
// writes when full and reads when empty are ignored
`timescale 1ns/1ps

module readback_fifo import link_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  logic  wr_en_i,
  input  byte_t wr_data_i,
  output logic  full_o,
  input  logic  rd_en_i,
  output byte_t rd_data_o,
  output logic  empty_o
);

  typedef logic [RB_PTR_W:0] cnt_t;

  byte_t               mem_q [RB_DEPTH];
  logic [RB_PTR_W-1:0] wr_ptr_q;
  logic [RB_PTR_W-1:0] rd_ptr_q;
  cnt_t                count_q;
  cnt_t                count_w;
  logic                full_q;
  logic                empty_q;
  logic                wr_ok_w;
  logic                rd_ok_w;

  assign wr_ok_w = wr_en_i && !full_q;
  assign rd_ok_w = rd_en_i && !empty_q;

  // occupancy after this cycle
  always_comb begin
    count_w = count_q;
    if (wr_ok_w && !rd_ok_w) begin
      count_w = count_q + 1'b1;
    end else if (rd_ok_w && !wr_ok_w) begin
      count_w = count_q - 1'b1;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (wr_ok_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_w;
      full_q  <= (count_w == cnt_t'(RB_DEPTH));
      empty_q <= (count_w == '0);
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (wr_ok_w) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  assign rd_data_o = mem_q[rd_ptr_q];
  assign full_o    = full_q;
  assign empty_o   = empty_q;

endmodule

// File: src/slm_bridge_top.sv
// host control path of the slm board
// uart rx -> byte pairing / spi master -> readback fifo -> uart tx
// plus the stretcher for the active-low display reset
`timescale 1ns/1ps

module slm_bridge_top import link_pkg::*; (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_cs_n_o,
  output logic spi_sck_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i,
  output logic slm_reset_n_o
);

  typedef logic [$clog2(RESET_HOLD_CYCLES + 1)-1:0] hold_t;

  byte_t rx_byte;
  logic  rx_valid;
  logic  rb_wr_en;
  byte_t rb_wr_data;
  logic  rb_full;
  logic  rb_rd_en;
  byte_t rb_rd_data;
  logic  rb_empty;
  hold_t hold_cnt_q;

  ////////////////////////////////////////////////////////////
  // display reset stretcher
  ////////////////////////////////////////////////////////////
  // reloads while the command is high, then counts out
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt_q <= hold_t'(RESET_HOLD_CYCLES);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // display reset low while counting
  assign slm_reset_n_o = (hold_cnt_q == '0);

  ////////////////////////////////////////////////////////////
  // command / readback chain
  ////////////////////////////////////////////////////////////
  uart_rx i_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .rx_byte_o       (rx_byte),
    .rx_valid_o      (rx_valid)
  );

  spi_cmd_master i_spi_cmd_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_byte_i       (rx_byte),
    .rx_valid_i      (rx_valid),
    .rb_full_i       (rb_full),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i),
    .rb_wr_en_o      (rb_wr_en),
    .rb_wr_data_o    (rb_wr_data)
  );

  readback_fifo i_readback_fifo (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .wr_en_i         (rb_wr_en),
    .wr_data_i       (rb_wr_data),
    .full_o          (rb_full),
    .rd_en_i         (rb_rd_en),
    .rd_data_o       (rb_rd_data),
    .empty_o         (rb_empty)
  );

  uart_readback_tx i_uart_readback_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rb_empty_i      (rb_empty),
    .rb_rd_en_o      (rb_rd_en),
    .rb_rd_data_i    (rb_rd_data),
    .uart_tx_o       (uart_tx_o)
  );

endmodule

// File: src/slm_pkg.sv
// display side definitions
// spi frame shape, command address values and the
// states of the spi frame engine

package slm_pkg;

  // sck half period in fpga_clk cycles
  localparam int SPI_CLK_DIV = 2;

  // address byte then data byte
  localparam int SPI_FRAME_BITS = 16;

  // command addresses with special handling
  // any other address is a plain register write
  typedef enum logic [7:0] {
    OP_LINE_BURST = 8'hBC
  } slm_opcode_e;

  // frame engine
  // SPI_HOLD keeps chip select low between burst frames
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_HOLD
  } spi_state_e;

endpackage

// File: src/spi_cmd_master.sv
// spi command master for the display driver
// pairs host bytes into address and data, sends one 16 bit
// mode 0 frame per pair and captures the readback byte
// from miso during the data half
// a line-burst address keeps chip select low into the next frame
`timescale 1ns/1ps

module spi_cmd_master import link_pkg::*, slm_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  byte_t rx_byte_i,
  input  logic  rx_valid_i,
  input  logic  rb_full_i,
  output logic  spi_cs_n_o,
  output logic  spi_sck_o,
  output logic  spi_mosi_o,
  input  logic  spi_miso_i,
  output logic  rb_wr_en_o,
  output byte_t rb_wr_data_o
);

  typedef logic [$clog2(SPI_CLK_DIV)-1:0]    div_t;
  typedef logic [$clog2(SPI_FRAME_BITS)-1:0] bit_t;

  spi_state_e                state_q;
  logic                      pair_half_q;
  byte_t                     addr_q;
  logic                      burst_q;
  logic [SPI_FRAME_BITS-1:0] shift_q;
  div_t                      div_q;
  bit_t                      bit_q;
  logic                      sck_q;
  logic                      cs_n_q;
  logic                      wr_en_q;
  byte_t                     rb_q;
  logic                      pair_done_w;
  logic                      half_done_w;
  logic                      rise_w;
  logic                      last_fall_w;

  ////////////////////////////////////////////////////////////
  // byte pairing
  ////////////////////////////////////////////////////////////
  // pair_half_q high = address held, next byte is data
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      pair_half_q <= 1'b0;
    end else if (rx_valid_i) begin
      pair_half_q <= !pair_half_q;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i && !pair_half_q) begin
      addr_q <= rx_byte_i;
    end
  end

  assign pair_done_w = rx_valid_i && pair_half_q;

  // sck edge strobes
  assign half_done_w = (state_q == SPI_SHIFT) && (div_q == div_t'(SPI_CLK_DIV - 1));
  assign rise_w      = half_done_w && !sck_q;
  assign last_fall_w = half_done_w && sck_q && (bit_q == bit_t'(SPI_FRAME_BITS - 1));

  ////////////////////////////////////////////////////////////
  // frame engine
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q <= SPI_IDLE;
      shift_q <= '0;
      div_q   <= '0;
      bit_q   <= '0;
      sck_q   <= 1'b0;
      cs_n_q  <= 1'b1;
      burst_q <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      case (state_q)
        SPI_IDLE, SPI_HOLD: begin
          // address on the upper half, goes out first
          if (pair_done_w) begin
            state_q <= SPI_SHIFT;
            cs_n_q  <= 1'b0;
            shift_q <= {addr_q, rx_byte_i};
            burst_q <= (addr_q == byte_t'(OP_LINE_BURST));
            div_q   <= '0;
            bit_q   <= '0;
          end
        end
        SPI_SHIFT: begin
          // a pair landing mid-frame is ignored
          div_q <= half_done_w ? '0 : div_q + 1'b1;
          if (half_done_w) begin
            sck_q <= !sck_q;
            if (last_fall_w) begin
              // frame end, push readback unless buffer full
              shift_q <= '0;
              wr_en_q <= !rb_full_i;
              if (burst_q) begin
                state_q <= SPI_HOLD;
              end else begin
                state_q <= SPI_IDLE;
                cs_n_q  <= 1'b1;
              end
            end else if (sck_q) begin
              // falling sck, next bit onto mosi
              shift_q <= {shift_q[SPI_FRAME_BITS-2:0], 1'b0};
              bit_q   <= bit_q + 1'b1;
            end
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // miso sampled on rising sck, data half only, MSB first
  always_ff @(posedge fpga_clk) begin
    if (rise_w && bit_q >= bit_t'(SPI_FRAME_BITS / 2)) begin
      rb_q <= {rb_q[BYTE_W-2:0], spi_miso_i};
    end
  end

  assign spi_cs_n_o   = cs_n_q;
  assign spi_sck_o    = sck_q;
  assign spi_mosi_o   = shift_q[SPI_FRAME_BITS-1];
  assign rb_wr_en_o   = wr_en_q;
  assign rb_wr_data_o = rb_q;

endmodule

// File: src/uart_readback_tx.sv
// uart transmitter for readback bytes
// pops the fifo head whenever the line is idle and sends
// start bit, eight data bits LSB first, stop bit
`timescale 1ns/1ps

module uart_readback_tx import link_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  logic  rb_empty_i,
  output logic  rb_rd_en_o,
  input  byte_t rb_rd_data_i,
  output logic  uart_tx_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef logic [$clog2(CLKS_PER_BIT)-1:0] cnt_t;
  typedef logic [$clog2(BYTE_W)-1:0] idx_t;

  tx_state_e state_q;
  cnt_t      clk_cnt_q;
  idx_t      bit_idx_q;
  logic      tx_q;
  logic      bit_end_w;
  logic      pop_w;
  byte_t     tx_byte_q;

  // idle + data waiting = pop now, start bit next cycle
  assign pop_w      = (state_q == TX_IDLE) && !rb_empty_i;
  assign bit_end_w  = (clk_cnt_q == cnt_t'(CLKS_PER_BIT - 1));
  assign rb_rd_en_o = pop_w;

  ////////////////////////////////////////////////////////////
  // bit sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;
    end else begin
      if (state_q == TX_IDLE || bit_end_w) begin
        clk_cnt_q <= '0;
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
      case (state_q)
        TX_IDLE: begin
          bit_idx_q <= '0;
          if (pop_w) begin
            tx_q    <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end_w) begin
            tx_q    <= tx_byte_q[0];
            state_q <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end_w) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == idx_t'(BYTE_W - 1)) begin
              tx_q    <= 1'b1;
              state_q <= TX_STOP;
            end else begin
              tx_q <= tx_byte_q[0];
            end
          end
        end
        TX_STOP: begin
          // full stop bit before the next pop
          if (bit_end_w) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // byte latched with the pop, shifted down as bits go out
  always_ff @(posedge fpga_clk) begin
    if (pop_w) begin
      tx_byte_q <= rb_rd_data_i;
    end else if ((state_q == TX_START || state_q == TX_DATA) && bit_end_w) begin
      tx_byte_q <= tx_byte_q >> 1;
    end
  end

  assign uart_tx_o = tx_q;

endmodule

// File: src/uart_rx.sv
// uart receiver for the host command link
// samples each bit at its centre, LSB first
// one-cycle valid per byte, bytes with a bad stop bit are dropped
`timescale 1ns/1ps

module uart_rx import link_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  logic  uart_rx_i,
  output byte_t rx_byte_o,
  output logic  rx_valid_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
  typedef logic [$clog2(CLKS_PER_BIT)-1:0] cnt_t;
  typedef logic [$clog2(BYTE_W)-1:0] idx_t;

  rx_state_e state_q;
  cnt_t      clk_cnt_q;
  idx_t      bit_idx_q;
  logic      rx_meta_q;
  logic      rx_sync_q;
  logic      sample_w;
  logic      valid_q;
  byte_t     shift_q;

  // two flop sync, line idles high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= uart_rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // half a bit to the start centre, whole bits after that
  assign sample_w = (state_q == RX_START) ? (clk_cnt_q == cnt_t'(CLKS_PER_BIT / 2 - 1)) :
                                            (clk_cnt_q == cnt_t'(CLKS_PER_BIT - 1));

  ////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (state_q == RX_IDLE || sample_w) begin
        clk_cnt_q <= '0;
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
      case (state_q)
        RX_IDLE: begin
          bit_idx_q <= '0;
          // falling edge = start bit
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // glitch check at start centre
          if (sample_w) begin
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (sample_w) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == idx_t'(BYTE_W - 1)) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          // only a high stop bit releases the byte
          if (sample_w) begin
            valid_q <= rx_sync_q;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // data bits arrive LSB first, shift in from the top
  always_ff @(posedge fpga_clk) begin
    if (state_q == RX_DATA && sample_w) begin
      shift_q <= {rx_sync_q, shift_q[BYTE_W-1:1]};
    end
  end

  assign rx_byte_o  = shift_q;
  assign rx_valid_o = valid_q;

endmodule
